// ==== src/sd_pkg.sv ====
`default_nettype none

package sd_pkg;

    // ========================================================================
    // Frame layout
    // ========================================================================
    // Command and response frames are both 48 bits on CMD
    localparam int unsigned FRAME_BITS   = 48;
    localparam int unsigned CRC_BITS     = 7;
    // Start, direction, index and argument are covered by CRC7
    localparam int unsigned PAYLOAD_BITS = 40;

    typedef enum logic {
        RESP_NONE,
        RESP_48
    } resp_type_e;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        resp_type_e  resp_type;
    } cmd_req_t;

    typedef struct packed {
        logic [FRAME_BITS-1:0] data;
        logic                  crc_err;
    } resp_t;

    // Pin request handed from a block to the top level
    typedef struct packed {
        logic clk_high;
        logic cmd_oe;
        logic cmd_out;
    } pin_drive_t;

    // ========================================================================
    // FSM states
    // ========================================================================
    typedef enum logic [2:0] {
        INIT_IDLE,
        INIT_PULSE,
        INIT_HOLD,
        INIT_RELEASE,
        INIT_SETTLE,
        INIT_DONE
    } init_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SHIFT,
        TX_CRC,
        TX_END
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_TURN,
        RX_WAIT_START,
        RX_SHIFT,
        RX_CHECK
    } rx_state_e;

endpackage

`default_nettype wire

// ==== src/sd_crc7.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_crc7 (
    input  wire                          clk_fast,
    input  wire                          init_resetPulse,
    input  wire                          clear,
    input  wire                          shift_en,
    input  wire                          data_in,
    output logic [sd_pkg::CRC_BITS-1:0]  crc
);

    logic feedback;

    // Polynomial x^7 + x^3 + 1, fed MSB first
    assign feedback = crc[6] ^ data_in;

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse || clear) begin
            crc <= '0;
        end else if (shift_en) begin
            crc[6] <= crc[5];
            crc[5] <= crc[4];
            crc[4] <= crc[3];
            // Tap for the x^3 term
            crc[3] <= crc[2] ^ feedback;
            crc[2] <= crc[1];
            crc[1] <= crc[0];
            crc[0] <= feedback;
        end
    end

endmodule

`default_nettype wire

// ==== src/sd_init_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_init_seq #(
    parameter int unsigned INIT_PULSE_CYCLES  = 300,
    parameter int unsigned INIT_HOLD_CYCLES   = 100,
    parameter int unsigned INIT_FINISH_CYCLES = 200
) (
    input  wire                 clk_fast,
    input  wire                 init_resetPulse,
    input  wire                 init_trigger,
    output sd_pkg::pin_drive_t  init_pins,
    output logic                init_done
);

    localparam int unsigned MAX_A     = (INIT_PULSE_CYCLES > INIT_HOLD_CYCLES) ?
                                        INIT_PULSE_CYCLES : INIT_HOLD_CYCLES;
    localparam int unsigned MAX_DELAY = (MAX_A > INIT_FINISH_CYCLES) ?
                                        MAX_A : INIT_FINISH_CYCLES;
    localparam int unsigned CNT_W     = $clog2(MAX_DELAY + 1);

    sd_pkg::init_state_e state;
    logic [CNT_W-1:0]    delay_cnt;

    // A trigger restarts the sequence from any state, done included
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state     <= sd_pkg::INIT_IDLE;
            delay_cnt <= '0;
        end else if (init_trigger) begin
            state     <= sd_pkg::INIT_PULSE;
            delay_cnt <= CNT_W'(INIT_PULSE_CYCLES - 1);
        end else begin
            case (state)
                sd_pkg::INIT_PULSE: begin
                    if (delay_cnt == '0) begin
                        state     <= sd_pkg::INIT_HOLD;
                        delay_cnt <= CNT_W'(INIT_HOLD_CYCLES - 1);
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                sd_pkg::INIT_HOLD: begin
                    if (delay_cnt == '0) begin
                        state <= sd_pkg::INIT_RELEASE;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                // First released cycle, counts toward the settle time
                sd_pkg::INIT_RELEASE: begin
                    state     <= sd_pkg::INIT_SETTLE;
                    delay_cnt <= CNT_W'(INIT_FINISH_CYCLES - 2);
                end
                sd_pkg::INIT_SETTLE: begin
                    if (delay_cnt == '0) begin
                        state <= sd_pkg::INIT_DONE;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Pin levels follow the state directly
    always_comb begin
        init_pins.clk_high = (state == sd_pkg::INIT_PULSE);
        init_pins.cmd_oe   = (state == sd_pkg::INIT_IDLE) ||
                             (state == sd_pkg::INIT_PULSE) ||
                             (state == sd_pkg::INIT_HOLD);
        init_pins.cmd_out  = 1'b0;
    end

    assign init_done = (state == sd_pkg::INIT_DONE);

endmodule

`default_nettype wire

// ==== src/sd_cmd_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_tx (
    input  wire                 clk_fast,
    input  wire                 init_resetPulse,
    input  wire                 start,
    input  wire sd_pkg::cmd_req_t cmd_req,
    output sd_pkg::pin_drive_t  tx_pins,
    output logic                tx_busy,
    output logic                tx_done,
    output sd_pkg::resp_type_e  expect_resp
);

    localparam int unsigned CNT_W = $clog2(sd_pkg::PAYLOAD_BITS);

    sd_pkg::tx_state_e              state;
    sd_pkg::resp_type_e             resp_type_q;
    logic [sd_pkg::FRAME_BITS-1:0]  shreg;
    logic [CNT_W-1:0]               bit_cnt;
    logic [sd_pkg::CRC_BITS-1:0]    crc;
    logic                           accept;

    assign accept = start && (state == sd_pkg::TX_IDLE);

    sd_crc7 i_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (accept),
        .shift_en        (state == sd_pkg::TX_SHIFT),
        .data_in         (shreg[sd_pkg::FRAME_BITS-1]),
        .crc             (crc)
    );

    // ========================================================================
    // Phase control
    // ========================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state       <= sd_pkg::TX_IDLE;
            bit_cnt     <= '0;
            resp_type_q <= sd_pkg::RESP_NONE;
        end else begin
            case (state)
                sd_pkg::TX_IDLE: begin
                    if (accept) begin
                        state       <= sd_pkg::TX_SHIFT;
                        bit_cnt     <= CNT_W'(sd_pkg::PAYLOAD_BITS - 1);
                        resp_type_q <= cmd_req.resp_type;
                    end
                end
                sd_pkg::TX_SHIFT: begin
                    if (bit_cnt == '0) begin
                        state   <= sd_pkg::TX_CRC;
                        bit_cnt <= CNT_W'(sd_pkg::CRC_BITS - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                sd_pkg::TX_CRC: begin
                    if (bit_cnt == '0) begin
                        state <= sd_pkg::TX_END;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= sd_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Frame with a blank CRC field, filled on the fly from the generator
    always_ff @(posedge clk_fast) begin
        if (accept) begin
            shreg <= {1'b0, 1'b1, cmd_req.index, cmd_req.arg,
                      {sd_pkg::CRC_BITS{1'b0}}, 1'b1};
        end else if (state == sd_pkg::TX_SHIFT || state == sd_pkg::TX_CRC) begin
            shreg <= {shreg[sd_pkg::FRAME_BITS-2:0], 1'b1};
        end
    end

    // ========================================================================
    // Registered CMD output
    // ========================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            tx_pins <= '{clk_high: 1'b0, cmd_oe: 1'b0, cmd_out: 1'b1};
            tx_done <= 1'b0;
        end else begin
            // Pins still driving while the FSM is back in idle means the end bit is out
            tx_done          <= tx_pins.cmd_oe && (state == sd_pkg::TX_IDLE);
            tx_pins.clk_high <= 1'b0;
            case (state)
                sd_pkg::TX_IDLE: begin
                    tx_pins.cmd_oe  <= 1'b0;
                    tx_pins.cmd_out <= 1'b1;
                end
                sd_pkg::TX_CRC: begin
                    tx_pins.cmd_oe  <= 1'b1;
                    tx_pins.cmd_out <= crc[bit_cnt[2:0]];
                end
                default: begin
                    tx_pins.cmd_oe  <= 1'b1;
                    tx_pins.cmd_out <= shreg[sd_pkg::FRAME_BITS-1];
                end
            endcase
        end
    end

    assign tx_busy     = (state != sd_pkg::TX_IDLE) || tx_pins.cmd_oe || tx_done;
    assign expect_resp = resp_type_q;

endmodule

`default_nettype wire

// ==== src/sd_resp_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_resp_rx (
    input  wire                     clk_fast,
    input  wire                     init_resetPulse,
    input  wire                     tx_done,
    input  wire sd_pkg::resp_type_e expect_resp,
    input  wire                     cmd_in,
    output sd_pkg::resp_t           resp,
    output logic                    resp_done,
    output logic                    rx_busy
);

    localparam int unsigned CNT_W       = $clog2(sd_pkg::FRAME_BITS);
    localparam int unsigned TURN_CYCLES = 2;
    // Lowest frame bit position still covered by the CRC
    localparam int unsigned CRC_LOW     = sd_pkg::FRAME_BITS - sd_pkg::PAYLOAD_BITS;

    sd_pkg::rx_state_e              state;
    logic [CNT_W-1:0]               cnt;
    logic [sd_pkg::FRAME_BITS-1:0]  shreg;
    logic [sd_pkg::CRC_BITS-1:0]    crc;
    logic                           resp_start;
    logic                           start_bit;
    logic                           shift_in;
    logic                           crc_en;
    logic                           crc_err;

    assign resp_start = (state == sd_pkg::RX_IDLE) && tx_done &&
                        (expect_resp == sd_pkg::RESP_48);
    assign start_bit  = (state == sd_pkg::RX_WAIT_START) && !cmd_in;
    assign shift_in   = start_bit || (state == sd_pkg::RX_SHIFT);

    // cnt holds the frame bit position being received while shifting
    assign crc_en     = start_bit ||
                        ((state == sd_pkg::RX_SHIFT) && (cnt >= CNT_W'(CRC_LOW)));

    sd_crc7 i_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (resp_start),
        .shift_en        (crc_en),
        .data_in         (cmd_in),
        .crc             (crc)
    );

    // ========================================================================
    // Receive FSM
    // ========================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state     <= sd_pkg::RX_IDLE;
            cnt       <= '0;
            resp_done <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            case (state)
                sd_pkg::RX_IDLE: begin
                    if (resp_start) begin
                        state <= sd_pkg::RX_TURN;
                        cnt   <= CNT_W'(TURN_CYCLES - 1);
                    end
                end
                // CMD is still turning around, ignore it
                sd_pkg::RX_TURN: begin
                    if (cnt == '0) begin
                        state <= sd_pkg::RX_WAIT_START;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                // No timeout, the card decides when to answer
                sd_pkg::RX_WAIT_START: begin
                    if (start_bit) begin
                        state <= sd_pkg::RX_SHIFT;
                        cnt   <= CNT_W'(sd_pkg::FRAME_BITS - 2);
                    end
                end
                sd_pkg::RX_SHIFT: begin
                    if (cnt == '0) begin
                        state <= sd_pkg::RX_CHECK;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                sd_pkg::RX_CHECK: begin
                    resp_done <= 1'b1;
                    state     <= sd_pkg::RX_IDLE;
                end
                default: begin
                    state <= sd_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // ========================================================================
    // Frame capture and check
    // ========================================================================
    // Bad CRC field, or end bit not 1
    assign crc_err = (shreg[sd_pkg::CRC_BITS:1] != crc) || !shreg[0];

    always_ff @(posedge clk_fast) begin
        if (shift_in) begin
            shreg <= {shreg[sd_pkg::FRAME_BITS-2:0], cmd_in};
        end
        if (state == sd_pkg::RX_CHECK) begin
            resp.data    <= shreg;
            resp.crc_err <= crc_err;
        end
    end

    assign rx_busy = (state != sd_pkg::RX_IDLE);

endmodule

`default_nettype wire

// ==== src/sd_cmd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_ctrl #(
    parameter int unsigned INIT_PULSE_CYCLES  = 300,
    parameter int unsigned INIT_HOLD_CYCLES   = 100,
    parameter int unsigned INIT_FINISH_CYCLES = 200
) (
    input  wire                   clk_fast,
    input  wire                   init_resetPulse,

    // Init port
    input  wire                   init_trigger,
    output logic                  init_done,

    // Command port
    input  wire                   cmd_trigger,
    input  wire sd_pkg::cmd_req_t cmd_req,
    output logic                  cmd_done,
    output logic                  cmd_busy,

    // Response port
    output logic                  resp_done,
    output sd_pkg::resp_t         resp,

    // SD card pins
    output logic                  sd_clk,
    output logic                  sd_cmd_out,
    output logic                  sd_cmd_oe,
    input  wire                   sd_cmd_in
);

    sd_pkg::pin_drive_t  init_pins;
    sd_pkg::pin_drive_t  tx_pins;
    sd_pkg::resp_type_e  expect_resp;
    logic                tx_busy;
    logic                rx_busy;
    logic                cmd_start;

    // Triggers before init or while a command is in flight are dropped
    assign cmd_start = cmd_trigger && init_done && !cmd_busy;
    assign cmd_busy  = tx_busy || rx_busy;

    sd_init_seq #(
        .INIT_PULSE_CYCLES  (INIT_PULSE_CYCLES),
        .INIT_HOLD_CYCLES   (INIT_HOLD_CYCLES),
        .INIT_FINISH_CYCLES (INIT_FINISH_CYCLES)
    ) i_init_seq (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .init_trigger    (init_trigger),
        .init_pins       (init_pins),
        .init_done       (init_done)
    );

    sd_cmd_tx i_cmd_tx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .start           (cmd_start),
        .cmd_req         (cmd_req),
        .tx_pins         (tx_pins),
        .tx_busy         (tx_busy),
        .tx_done         (cmd_done),
        .expect_resp     (expect_resp)
    );

    sd_resp_rx i_resp_rx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .tx_done         (cmd_done),
        .expect_resp     (expect_resp),
        .cmd_in          (sd_cmd_in),
        .resp            (resp),
        .resp_done       (resp_done),
        .rx_busy         (rx_busy)
    );

    // ========================================================================
    // Pin ownership
    // ========================================================================
    // Init sequencer owns the pins until it is done, then the card runs on clk_fast
    assign sd_clk     = init_done ? clk_fast        : init_pins.clk_high;
    assign sd_cmd_oe  = init_done ? tx_pins.cmd_oe  : init_pins.cmd_oe;
    assign sd_cmd_out = init_done ? tx_pins.cmd_out : init_pins.cmd_out;

endmodule

`default_nettype wire

// ==== test/sd_card_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_card_model (
    input  wire         clk_fast,
    input  wire         bus_ready,
    input  wire         sd_cmd_out,
    input  wire         sd_cmd_oe,
    output logic        sd_cmd_in,
    // Reply settings, chosen by the testbench per command
    input  wire         expect_reply,
    input  wire  [31:0] reply_word,
    input  wire  [4:0]  reply_delay,
    input  wire         flip_crc,
    input  wire         zero_end,
    // Last captured command and last reply sent
    output logic [47:0] frame,
    output logic [6:0]  frame_crc,
    output int          frame_count,
    output logic [47:0] reply_frame,
    output logic [63:0] start_time
);

    // Serial CRC7, polynomial x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] calc_crc7(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = c[6] ^ bits[i];
            c = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    task automatic send_reply();
        logic [47:0] f;
        f[47:40] = {1'b0, 1'b0, frame[45:40]};
        f[39:8]  = reply_word;
        f[7:1]   = calc_crc7(f[47:8]);
        f[0]     = 1'b1;
        if (flip_crc) begin
            f[4] = ~f[4];
        end
        if (zero_end) begin
            f[0] = 1'b0;
        end
        reply_frame = f;
        // Stay off the line until the host turnaround is over
        repeat (2 + int'(reply_delay)) @(posedge clk_fast);
        for (int i = 47; i >= 0; i--) begin
            #2 sd_cmd_in = f[i];
            @(posedge clk_fast);
            if (i == 47) begin
                start_time = $time;
            end
        end
        #2 sd_cmd_in = 1'b1;
    endtask

    initial begin
        logic [47:0] shift;
        int          nbits;
        sd_cmd_in   = 1'b1;
        frame       = '0;
        frame_crc   = '0;
        frame_count = 0;
        reply_frame = '0;
        start_time  = '0;
        shift       = '0;
        nbits       = 0;
        forever begin
            @(posedge clk_fast);
            if (bus_ready && sd_cmd_oe) begin
                shift = {shift[46:0], sd_cmd_out};
                nbits++;
                if (nbits == 48) begin
                    frame       = shift;
                    frame_crc   = calc_crc7(shift[47:8]);
                    frame_count = frame_count + 1;
                    nbits       = 0;
                    if (expect_reply) begin
                        send_reply();
                    end
                end
            end else begin
                nbits = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_sd_cmd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sd_cmd_ctrl;

    // Init takes about 600 cycles, each command well under 250
    localparam int TIMEOUT_CYCLES = 20000;

    logic               clk_fast = 1'b0;
    logic               init_resetPulse;
    logic               init_trigger;
    logic               cmd_trigger;
    sd_pkg::cmd_req_t   cmd_req;
    wire                init_done;
    wire                cmd_done;
    wire                cmd_busy;
    wire                resp_done;
    sd_pkg::resp_t      resp;
    wire                sd_clk;
    wire                sd_cmd_out;
    wire                sd_cmd_oe;
    wire                sd_cmd_in;

    logic               expect_reply;
    logic [31:0]        reply_word;
    logic [4:0]         reply_delay;
    logic               flip_crc;
    logic               zero_end;
    wire  [47:0]        frame;
    wire  [6:0]         frame_crc;
    int                 frame_count;
    wire  [47:0]        reply_frame;
    wire  [63:0]        start_time;
    int                 cycles = 0;

    sd_cmd_ctrl i_dut (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .init_trigger    (init_trigger),
        .init_done       (init_done),
        .cmd_trigger     (cmd_trigger),
        .cmd_req         (cmd_req),
        .cmd_done        (cmd_done),
        .cmd_busy        (cmd_busy),
        .resp_done       (resp_done),
        .resp            (resp),
        .sd_clk          (sd_clk),
        .sd_cmd_out      (sd_cmd_out),
        .sd_cmd_oe       (sd_cmd_oe),
        .sd_cmd_in       (sd_cmd_in)
    );

    sd_card_model i_card (
        .clk_fast     (clk_fast),
        .bus_ready    (init_done),
        .sd_cmd_out   (sd_cmd_out),
        .sd_cmd_oe    (sd_cmd_oe),
        .sd_cmd_in    (sd_cmd_in),
        .expect_reply (expect_reply),
        .reply_word   (reply_word),
        .reply_delay  (reply_delay),
        .flip_crc     (flip_crc),
        .zero_end     (zero_end),
        .frame        (frame),
        .frame_crc    (frame_crc),
        .frame_count  (frame_count),
        .reply_frame  (reply_frame),
        .start_time   (start_time)
    );

    always #10 clk_fast = ~clk_fast;

    always @(posedge clk_fast) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic run_init();
        @(posedge clk_fast);
        #2 init_trigger = 1'b1;
        @(posedge clk_fast);
        #2 init_trigger = 1'b0;
        repeat (300) begin
            @(negedge clk_fast);
            check_value("sd_clk", 64'(sd_clk), 64'd1);
        end
        repeat (100) begin
            @(negedge clk_fast);
            check_value("sd_clk", 64'(sd_clk), 64'd0);
            check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd1);
            check_value("sd_cmd_out", 64'(sd_cmd_out), 64'd0);
        end
        repeat (200) begin
            @(negedge clk_fast);
            check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd0);
            check_value("init_done", 64'(init_done), 64'd0);
        end
        @(negedge clk_fast);
        check_value("init_done", 64'(init_done), 64'd1);
        // After init the card clock follows clk_fast
        @(posedge clk_fast);
        #2;
        check_value("sd_clk", 64'(sd_clk), 64'd1);
    endtask

    task automatic run_cmd(input sd_pkg::resp_type_e rtype, input logic flip,
                           input logic zero, input logic poke);
        logic [5:0]  idx;
        logic [31:0] arg;
        int          count;
        int          base;
        int          poke_wait;
        idx          = 6'($urandom);
        arg          = $urandom;
        reply_word   = $urandom;
        reply_delay  = 5'($urandom_range(20, 1));
        expect_reply = (rtype == sd_pkg::RESP_48);
        flip_crc     = flip;
        zero_end     = zero;
        base         = frame_count;
        // Response commands are poked while the receiver waits, others mid frame
        poke_wait    = (rtype == sd_pkg::RESP_48) ? 52 : 3;
        @(posedge clk_fast);
        #2;
        cmd_req.index     = idx;
        cmd_req.arg       = arg;
        cmd_req.resp_type = rtype;
        cmd_trigger       = 1'b1;
        @(posedge clk_fast);
        #2 cmd_trigger = 1'b0;
        // Second trigger while the command is still busy
        if (poke) begin
            fork
                begin
                    repeat (poke_wait) @(posedge clk_fast);
                    #2 cmd_trigger = 1'b1;
                    @(posedge clk_fast);
                    #2 cmd_trigger = 1'b0;
                end
            join_none
        end
        @(negedge clk_fast);
        check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd0);
        @(negedge clk_fast);
        check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd1);
        count = 1;
        while (sd_cmd_oe) begin
            @(negedge clk_fast);
            if (sd_cmd_oe) begin
                count++;
            end
        end
        check_value("sd_cmd_oe length", 64'(count), 64'd48);
        check_value("cmd_done", 64'(cmd_done), 64'd1);
        check_value("frame_count", 64'(frame_count), 64'(base + 1));
        check_value("frame start", 64'(frame[47]), 64'd0);
        check_value("frame dir", 64'(frame[46]), 64'd1);
        check_value("frame index", 64'(frame[45:40]), 64'(idx));
        check_value("frame arg", 64'(frame[39:8]), 64'(arg));
        check_value("frame crc", 64'(frame[7:1]), 64'(frame_crc));
        check_value("frame end", 64'(frame[0]), 64'd1);
        @(negedge clk_fast);
        check_value("cmd_done", 64'(cmd_done), 64'd0);
        if (rtype == sd_pkg::RESP_48) begin
            while (!resp_done) begin
                @(negedge clk_fast);
                check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd0);
            end
            // Seen here means sampled 49 edges after the start bit
            check_value("resp_done delay", $time - start_time, 64'(48 * 20 + 10));
            check_value("resp.data", 64'(resp.data), 64'(reply_frame));
            check_value("resp.crc_err", 64'(resp.crc_err), 64'(flip || zero));
            check_value("cmd_busy", 64'(cmd_busy), 64'd0);
        end else begin
            repeat (100) begin
                @(negedge clk_fast);
                check_value("resp_done", 64'(resp_done), 64'd0);
            end
            check_value("cmd_busy", 64'(cmd_busy), 64'd0);
        end
    endtask

    initial begin
        sd_pkg::resp_type_e rtype;
        void'($urandom(2559));
        init_resetPulse = 1'b1;
        init_trigger    = 1'b0;
        cmd_trigger     = 1'b0;
        cmd_req         = '0;
        expect_reply    = 1'b0;
        reply_word      = '0;
        reply_delay     = 5'd1;
        flip_crc        = 1'b0;
        zero_end        = 1'b0;
        repeat (10) @(posedge clk_fast);
        #2 init_resetPulse = 1'b0;
        @(negedge clk_fast);
        check_value("init_done", 64'(init_done), 64'd0);
        check_value("cmd_busy", 64'(cmd_busy), 64'd0);
        check_value("cmd_done", 64'(cmd_done), 64'd0);
        check_value("resp_done", 64'(resp_done), 64'd0);

        // A command before init must be dropped
        @(posedge clk_fast);
        #2 cmd_trigger = 1'b1;
        @(posedge clk_fast);
        #2 cmd_trigger = 1'b0;
        repeat (20) begin
            @(negedge clk_fast);
            check_value("cmd_busy", 64'(cmd_busy), 64'd0);
        end

        run_init();
        check_value("frame_count", 64'(frame_count), 64'd0);

        for (int n = 0; n < 8; n++) begin
            rtype = (n == 2 || n == 5) ? sd_pkg::RESP_NONE : sd_pkg::RESP_48;
            run_cmd(rtype, n == 3, n == 6, n == 1 || n == 5);
        end
        check_value("frame_count", 64'(frame_count), 64'd8);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/sd_pkg.sv
src/sd_crc7.sv
src/sd_init_seq.sv
src/sd_cmd_tx.sv
src/sd_resp_rx.sv
src/sd_cmd_ctrl.sv
test/sd_card_model.sv
test/tb_sd_cmd_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SD command path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_sd_cmd_ctrl \
    -Mdir build \
    -f src.f

./build/Vtb_sd_cmd_ctrl
